//--- testbench/pfb_stim.txt
# name type(rd|pf) addr(hex) exp_hit exp_data(hex, read hits only) exp_mem_requests
# Memory word at address a is a with bits 31..16 inverted
rd_reset_a     rd 00001020 0 00000000 0
rd_reset_d     rd 12345658 0 00000000 0
rd_miss_x      rd deadbee0 0 00000000 0
pf_d           pf 12345650 0 00000000 1
rd_d_w0        rd 12345650 1 edcb5650 1
rd_d_w1        rd 12345654 1 edcb5654 1
rd_d_w2        rd 12345658 1 edcb5658 1
rd_d_w3        rd 1234565c 1 edcb565c 1
pf_d_again     pf 12345654 1 00000000 1
pf_a           pf 00001020 0 00000000 2
pf_b           pf 00002028 0 00000000 3
rd_a_w1        rd 00001024 1 ffff1024 3
pf_c           pf 0000302c 0 00000000 4
rd_a_w3        rd 0000102c 1 ffff102c 4
rd_c_w0        rd 00003020 1 ffff3020 4
rd_b_evicted   rd 00002020 0 00000000 4
pf_b_again     pf 00002020 0 00000000 5
rd_b_w1        rd 00002024 1 ffff2024 5
rd_a_evicted   rd 00001020 0 00000000 5
rd_c_w2        rd 00003028 1 ffff3028 5
pf_set0        pf 80000000 0 00000000 6
rd_set0_w3     rd 8000000c 1 7fff000c 6
rd_d_again     rd 1234565c 1 edcb565c 6
pf_set0_again  pf 80000004 1 00000000 6
rd_miss_y      rd 00000470 0 00000000 6

//--- list.f
hdl/pfb_pkg.sv
hdl/pfb_ctrl.sv
hdl/pfb_dpath.sv
hdl/prefetch_buffer.sv
testbench/tb_mem_model.sv
testbench/tb_prefetch_buffer.sv

//--- testbench/tb_prefetch_buffer.sv
/*
  Testbench for the prefetch buffer. Replays the requests of the stim file
  and checks every response and the running count of memory requests.
*/

`timescale 1ns/1ps

module tb_prefetch_buffer import pfb_pkg::*; ();

  logic                  clk;
  logic                  reset;
  logic                  cachereq_val;
  logic                  cachereq_rdy;
  pfb_req_e              cachereq_type;
  logic [addr_nbits-1:0] cachereq_addr;
  logic                  cacheresp_val;
  logic                  cacheresp_rdy;
  pfb_req_e              cacheresp_type;
  logic [data_nbits-1:0] cacheresp_data;
  logic                  cacheresp_hit;
  logic                  memreq_val;
  logic                  memreq_rdy;
  logic [addr_nbits-1:0] memreq_addr;
  logic                  memresp_val;
  logic                  memresp_rdy;
  logic [line_nbits-1:0] memresp_data;
  int                    mem_requests;
  int                    mem_addr_errors;

  // Stim lines
  string                 names[$];
  pfb_req_e              types[$];
  logic [addr_nbits-1:0] addrs[$];
  logic                  hits[$];
  logic [data_nbits-1:0] datas[$];
  int                    counts[$];

  int value_errors;
  int other_errors;
  int cycle_count;
  int cycle_limit;

  prefetch_buffer i_dut (
    .clk            (clk),
    .reset          (reset),
    .cachereq_val   (cachereq_val),
    .cachereq_rdy   (cachereq_rdy),
    .cachereq_type  (cachereq_type),
    .cachereq_addr  (cachereq_addr),
    .cacheresp_val  (cacheresp_val),
    .cacheresp_rdy  (cacheresp_rdy),
    .cacheresp_type (cacheresp_type),
    .cacheresp_data (cacheresp_data),
    .cacheresp_hit  (cacheresp_hit),
    .memreq_val     (memreq_val),
    .memreq_rdy     (memreq_rdy),
    .memreq_addr    (memreq_addr),
    .memresp_val    (memresp_val),
    .memresp_rdy    (memresp_rdy),
    .memresp_data   (memresp_data)
  );

  tb_mem_model i_mem (
    .clk          (clk),
    .reset        (reset),
    .memreq_val   (memreq_val),
    .memreq_rdy   (memreq_rdy),
    .memreq_addr  (memreq_addr),
    .memresp_val  (memresp_val),
    .memresp_rdy  (memresp_rdy),
    .memresp_data (memresp_data),
    .req_count    (mem_requests),
    .addr_errors  (mem_addr_errors)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic report_mismatch(input string name, input string field,
                                 input logic [31:0] expected, input logic [31:0] actual);
    value_errors++;
    $display("[FAIL] %s %s: expected %h, actual %h", name, field, expected, actual);
  endtask

  // One request, then its response under random back-pressure
  task automatic run_test(input int i);
    logic                  resp_hit;
    pfb_req_e              resp_type;
    logic [data_nbits-1:0] resp_data;
    bit                    got;
    @(negedge clk);
    while (!cachereq_rdy) @(negedge clk);
    cachereq_val  = 1'b1;
    cachereq_type = types[i];
    cachereq_addr = addrs[i];
    @(negedge clk);
    cachereq_val = 1'b0;
    got = 1'b0;
    while (!got) begin
      @(negedge clk);
      cacheresp_rdy = ($urandom % 3) != 0;
      if (cacheresp_val && cacheresp_rdy) begin
        got       = 1'b1;
        resp_hit  = cacheresp_hit;
        resp_type = cacheresp_type;
        resp_data = cacheresp_data;
      end
    end
    if (resp_type !== types[i]) report_mismatch(names[i], "type", types[i], resp_type);
    if (resp_hit !== hits[i]) report_mismatch(names[i], "hit", hits[i], resp_hit);
    if (types[i] == pfb_read && hits[i] && resp_data !== datas[i])
      report_mismatch(names[i], "data", datas[i], resp_data);
    if (mem_requests != counts[i])
      report_mismatch(names[i], "mem_requests", counts[i], mem_requests);
    @(negedge clk);
    cacheresp_rdy = 1'b0;
    if (cacheresp_val) begin
      other_errors++;
      $display("%s: response valid still high after its handshake", names[i]);
    end
  endtask

  initial begin
    int                    fd;
    int                    code;
    int                    n;
    int                    h;
    int                    c;
    string                 line;
    string                 name;
    string                 tstr;
    logic [addr_nbits-1:0] a;
    logic [data_nbits-1:0] d;
    void'($urandom(32'hb2d9));
    reset         = 1'b1;
    cachereq_val  = 1'b0;
    cachereq_type = pfb_read;
    cachereq_addr = '0;
    cacheresp_rdy = 1'b0;
    value_errors  = 0;
    other_errors  = 0;

    fd = $fopen("testbench/pfb_stim.txt", "r");
    if (fd == 0) begin
      other_errors++;
      $display("Could not open the stim file");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        code = $fgets(line, fd);
        if (code > 0 && line[0] != "#") begin
          n = $sscanf(line, "%s %s %h %d %h %d", name, tstr, a, h, d, c);
          if (n == 6) begin
            names.push_back(name);
            types.push_back(tstr == "pf" ? pfb_prefetch : pfb_read);
            addrs.push_back(a);
            hits.push_back(h != 0);
            datas.push_back(d);
            counts.push_back(c);
          end
        end
      end
      $fclose(fd);
    end
    if (names.size() == 0) begin
      other_errors++;
      $display("The stim file holds no requests");
    end
    cycle_limit = 40 * names.size() + 20;

    repeat (5) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Idle outputs right after reset
    if (cachereq_rdy !== 1'b1) report_mismatch("reset", "cachereq_rdy", 1, cachereq_rdy);
    if (cacheresp_val !== 1'b0) report_mismatch("reset", "cacheresp_val", 0, cacheresp_val);
    if (memreq_val !== 1'b0) report_mismatch("reset", "memreq_val", 0, memreq_val);
    if (memresp_rdy !== 1'b0) report_mismatch("reset", "memresp_rdy", 0, memresp_rdy);

    for (int i = 0; i < names.size(); i++) begin
      run_test(i);
    end

    other_errors += mem_addr_errors;
    $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  // Run limit
  initial begin
    cycle_count = 0;
    wait (cycle_limit > 0);
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout after %0d cycles, the run hung", cycle_count);
    $display("Verification failed");
    $finish;
  end

endmodule

//--- testbench/tb_mem_model.sv
/*
  Memory responder for the prefetch buffer testbench. Answers line requests
  after random delays and counts the requests it has accepted.
*/

`timescale 1ns/1ps

module tb_mem_model (
  input  logic         clk,
  input  logic         reset,
  input  logic         memreq_val,
  output logic         memreq_rdy,
  input  logic [31:0]  memreq_addr,
  output logic         memresp_val,
  input  logic         memresp_rdy,
  output logic [127:0] memresp_data,
  output int           req_count,
  output int           addr_errors
);

  int          delay;
  logic [31:0] base;

  // Word at byte address a is a with its upper half inverted
  function automatic logic [127:0] build_line(input logic [31:0] line_addr);
    logic [127:0] line;
    logic [31:0]  a;
    for (int i = 0; i < 4; i++) begin
      a = line_addr + 32'(4 * i);
      line[i*32 +: 32] = {~a[31:16], a[15:0]};
    end
    return line;
  endfunction

  initial begin
    memreq_rdy   = 1'b0;
    memresp_val  = 1'b0;
    memresp_data = '0;
    req_count    = 0;
    addr_errors  = 0;
    forever begin
      @(negedge clk);
      if (!reset && memreq_val) begin
        delay = $urandom % 6;
        repeat (delay) @(negedge clk);
        base = memreq_addr;
        if (base[3:0] != 4'h0) begin
          addr_errors++;
          $display("Memory request address %h is not line aligned", base);
        end
        // Handshake on the next rising edge
        memreq_rdy = 1'b1;
        req_count++;
        @(negedge clk);
        memreq_rdy = 1'b0;
        delay = $urandom % 6;
        repeat (delay) @(negedge clk);
        memresp_val  = 1'b1;
        memresp_data = build_line({base[31:4], 4'h0});
        while (!memresp_rdy) @(negedge clk);
        @(negedge clk);
        memresp_val  = 1'b0;
        memresp_data = '0;
      end
    end
  end

endmodule

//--- hdl/prefetch_buffer.sv
/*
  Top level of the two-way prefetch buffer. Joins the control unit and the
  datapath to the cache-side and memory-side val/rdy ports.
*/

`timescale 1ns/1ps

module prefetch_buffer import pfb_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,

  // Cache request
  input  logic                  cachereq_val,
  output logic                  cachereq_rdy,
  input  pfb_req_e              cachereq_type,
  input  logic [addr_nbits-1:0] cachereq_addr,

  // Cache response
  output logic                  cacheresp_val,
  input  logic                  cacheresp_rdy,
  output pfb_req_e              cacheresp_type,
  output logic [data_nbits-1:0] cacheresp_data,
  output logic                  cacheresp_hit,

  // Memory request
  output logic                  memreq_val,
  input  logic                  memreq_rdy,
  output logic [addr_nbits-1:0] memreq_addr,

  // Memory response
  input  logic                  memresp_val,
  output logic                  memresp_rdy,
  input  logic [line_nbits-1:0] memresp_data
);

  // Control word
  logic cachereq_en;
  logic tag_array_ren;
  logic tag_array_wen;
  logic data_array_wen;
  logic data_array_ren;
  logic read_data_reg_en;
  logic way_sel;

  // Status back to control
  pfb_req_e             req_type;
  logic [idx_nbits-1:0] req_idx;
  logic                 tag_match_0;
  logic                 tag_match_1;

  // Response echoes the latched request type
  assign cacheresp_type = req_type;

  pfb_ctrl i_ctrl (
    .clk              (clk),
    .reset            (reset),
    .cachereq_val     (cachereq_val),
    .cachereq_rdy     (cachereq_rdy),
    .cacheresp_val    (cacheresp_val),
    .cacheresp_rdy    (cacheresp_rdy),
    .memreq_val       (memreq_val),
    .memreq_rdy       (memreq_rdy),
    .memresp_val      (memresp_val),
    .memresp_rdy      (memresp_rdy),
    .cachereq_en      (cachereq_en),
    .tag_array_ren    (tag_array_ren),
    .tag_array_wen    (tag_array_wen),
    .data_array_wen   (data_array_wen),
    .data_array_ren   (data_array_ren),
    .read_data_reg_en (read_data_reg_en),
    .way_sel          (way_sel),
    .resp_hit         (cacheresp_hit),
    .cachereq_type    (req_type),
    .cachereq_idx     (req_idx),
    .tag_match_0      (tag_match_0),
    .tag_match_1      (tag_match_1)
  );

  pfb_dpath i_dpath (
    .clk              (clk),
    .reset            (reset),
    .cachereq_addr    (cachereq_addr),
    .cachereq_type_in (cachereq_type),
    .cachereq_en      (cachereq_en),
    .tag_array_ren    (tag_array_ren),
    .tag_array_wen    (tag_array_wen),
    .data_array_wen   (data_array_wen),
    .data_array_ren   (data_array_ren),
    .read_data_reg_en (read_data_reg_en),
    .way_sel          (way_sel),
    .memresp_data     (memresp_data),
    .cachereq_type    (req_type),
    .cachereq_idx     (req_idx),
    .tag_match_0      (tag_match_0),
    .tag_match_1      (tag_match_1),
    .memreq_addr      (memreq_addr),
    .cacheresp_data   (cacheresp_data)
  );

endmodule

//--- hdl/pfb_dpath.sv
/*
  Datapath of the prefetch buffer: request registers, tag and line storage
  for two ways, word select into the read data register and refill address.
*/

`timescale 1ns/1ps

module pfb_dpath import pfb_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,

  // Request fields from the cache side
  input  logic [addr_nbits-1:0] cachereq_addr,
  input  pfb_req_e              cachereq_type_in,

  // Control from pfb_ctrl
  input  logic                  cachereq_en,
  input  logic                  tag_array_ren,
  input  logic                  tag_array_wen,
  input  logic                  data_array_wen,
  input  logic                  data_array_ren,
  input  logic                  read_data_reg_en,
  input  logic                  way_sel,

  // Refill line from memory
  input  logic [line_nbits-1:0] memresp_data,

  // Status to pfb_ctrl
  output pfb_req_e              cachereq_type,
  output logic [idx_nbits-1:0]  cachereq_idx,
  output logic                  tag_match_0,
  output logic                  tag_match_1,

  // Outgoing payloads
  output logic [addr_nbits-1:0] memreq_addr,
  output logic [data_nbits-1:0] cacheresp_data
);

  // ----------------------------
  // Request registers
  // ----------------------------

  logic [addr_nbits-1:0] cachereq_addr_reg;

  always_ff @(posedge clk) begin
    if (cachereq_en) begin
      cachereq_addr_reg <= cachereq_addr;
      cachereq_type     <= cachereq_type_in;
    end
  end

  logic [tag_nbits-1:0] req_tag;
  logic [1:0]           req_word;

  assign req_tag      = cachereq_addr_reg[addr_nbits-1 -: tag_nbits];
  assign cachereq_idx = cachereq_addr_reg[offset_nbits +: idx_nbits];
  assign req_word     = cachereq_addr_reg[offset_nbits-1:2];

  // Line-aligned refill address
  assign memreq_addr = {req_tag, cachereq_idx, {offset_nbits{1'b0}}};

  // ----------------------------
  // Tag arrays
  // ----------------------------

  logic [tag_nbits-1:0] tag_array_0 [nsets];
  logic [tag_nbits-1:0] tag_array_1 [nsets];

  always_ff @(posedge clk) begin
    if (tag_array_wen && !way_sel) tag_array_0[cachereq_idx] <= req_tag;
    if (tag_array_wen && way_sel)  tag_array_1[cachereq_idx] <= req_tag;
  end

  // Compare only while the control reads the tags
  assign tag_match_0 = tag_array_ren && (tag_array_0[cachereq_idx] == req_tag);
  assign tag_match_1 = tag_array_ren && (tag_array_1[cachereq_idx] == req_tag);

  // ----------------------------
  // Line data array
  // ----------------------------

  // Holds the line seen on the memory response handshake for the update cycle
  logic [line_nbits-1:0] memresp_data_reg;

  always_ff @(posedge clk) begin
    memresp_data_reg <= memresp_data;
  end

  logic [line_nbits-1:0] data_array [2][nsets];

  always_ff @(posedge clk) begin
    if (data_array_wen) data_array[way_sel][cachereq_idx] <= memresp_data_reg;
  end

  // ----------------------------
  // Word select and read data
  // ----------------------------

  logic [line_nbits-1:0] read_line;
  logic [data_nbits-1:0] read_word;

  assign read_line = data_array[way_sel][cachereq_idx];
  assign read_word = read_line[req_word*data_nbits +: data_nbits];

  logic [data_nbits-1:0] read_data_reg;

  always_ff @(posedge clk) begin
    if (data_array_ren && read_data_reg_en) read_data_reg <= read_word;
  end

  assign cacheresp_data = read_data_reg;

  // ----------------------------
  // Assertions
  // ----------------------------

  // Refill writes a full line and its tag together
  a_data_with_tag: assert property (
    @(posedge clk) disable iff (reset) data_array_wen |-> tag_array_wen
  ) else $error("data array written without tag write");

endmodule

//--- hdl/pfb_ctrl.sv
/*
  Control unit of the prefetch buffer: FSM, per-set valid and LRU bits,
  way record and the per-state control word driven to the datapath.
*/

`timescale 1ns/1ps

module pfb_ctrl import pfb_pkg::*; (
  input  logic                 clk,
  input  logic                 reset,

  // Cache side handshakes
  input  logic                 cachereq_val,
  output logic                 cachereq_rdy,
  output logic                 cacheresp_val,
  input  logic                 cacheresp_rdy,

  // Memory side handshakes
  output logic                 memreq_val,
  input  logic                 memreq_rdy,
  input  logic                 memresp_val,
  output logic                 memresp_rdy,

  // Control to datapath
  output logic                 cachereq_en,
  output logic                 tag_array_ren,
  output logic                 tag_array_wen,
  output logic                 data_array_wen,
  output logic                 data_array_ren,
  output logic                 read_data_reg_en,
  output logic                 way_sel,
  output logic                 resp_hit,

  // Status from datapath
  input  pfb_req_e             cachereq_type,
  input  logic [idx_nbits-1:0] cachereq_idx,
  input  logic                 tag_match_0,
  input  logic                 tag_match_1
);

  // ----------------------------
  // State register
  // ----------------------------

  pfb_state_e state_reg;
  pfb_state_e state_next;

  always_ff @(posedge clk) begin
    if (reset) begin
      state_reg <= state_idle;
    end else begin
      state_reg <= state_next;
    end
  end

  // ----------------------------
  // Hit detection
  // ----------------------------

  logic [nsets-1:0] valid_bits_0;
  logic [nsets-1:0] valid_bits_1;
  logic [nsets-1:0] lru_bits;

  logic is_valid_0;
  logic is_valid_1;
  logic lru_way;

  assign is_valid_0 = valid_bits_0[cachereq_idx];
  assign is_valid_1 = valid_bits_1[cachereq_idx];
  assign lru_way    = lru_bits[cachereq_idx];

  logic in_go;
  logic out_go;
  logic hit_0;
  logic hit_1;
  logic hit;
  logic read_hit;
  logic prefetch_miss;

  assign in_go         = cachereq_val && cachereq_rdy;
  assign out_go        = cacheresp_val && cacheresp_rdy;
  assign hit_0         = is_valid_0 && tag_match_0;
  assign hit_1         = is_valid_1 && tag_match_1;
  assign hit           = hit_0 || hit_1;
  assign read_hit      = (cachereq_type == pfb_read) && hit;
  assign prefetch_miss = (cachereq_type == pfb_prefetch) && !hit;

  // ----------------------------
  // Next state
  // ----------------------------

  always_comb begin
    state_next = state_reg;
    case (state_reg)
      state_idle: begin
        if (in_go) state_next = state_tag_check;
      end
      state_tag_check: begin
        // Read misses and prefetch hits answer right away
        if (read_hit) begin
          state_next = state_read_access;
        end else if (prefetch_miss) begin
          state_next = state_refill_request;
        end else begin
          state_next = state_wait;
        end
      end
      state_read_access: begin
        state_next = state_wait;
      end
      state_refill_request: begin
        if (memreq_rdy) state_next = state_refill_wait;
      end
      state_refill_wait: begin
        if (memresp_val) state_next = state_refill_update;
      end
      state_refill_update: begin
        state_next = state_wait;
      end
      state_wait: begin
        if (out_go) state_next = state_idle;
      end
      default: begin
        state_next = state_idle;
      end
    endcase
  end

  // ----------------------------
  // Control word table
  // ----------------------------

  logic valid_bits_wen;
  logic lru_bits_wen;
  logic way_record_en;
  logic [12:0] cs;

  always_comb begin
    case (state_reg)
      //                           req resp mreq mresp en tren twen dwen dren rden vwen lwen wrec
      state_idle:           cs = 13'b1___0____0____0____1__0____0____0____0____0____0____0____0;
      state_tag_check:      cs = 13'b0___0____0____0____0__1____0____0____0____0____0____0____1;
      state_read_access:    cs = 13'b0___0____0____0____0__0____0____0____1____1____0____1____0;
      state_refill_request: cs = 13'b0___0____1____0____0__0____0____0____0____0____0____0____0;
      state_refill_wait:    cs = 13'b0___0____0____1____0__0____0____0____0____0____0____0____0;
      state_refill_update:  cs = 13'b0___0____0____0____0__0____1____1____0____0____1____1____0;
      state_wait:           cs = 13'b0___1____0____0____0__0____0____0____0____0____0____0____0;
      default:              cs = '0;
    endcase
  end

  assign {cachereq_rdy, cacheresp_val, memreq_val, memresp_rdy,
          cachereq_en, tag_array_ren, tag_array_wen, data_array_wen,
          data_array_ren, read_data_reg_en, valid_bits_wen, lru_bits_wen,
          way_record_en} = cs;

  // ----------------------------
  // Way record and response hit
  // ----------------------------

  // Hit way wins, otherwise the LRU way takes the refill
  logic way_record_in;

  assign way_record_in = hit ? !hit_0 : lru_way;

  always_ff @(posedge clk) begin
    if (reset) begin
      way_sel  <= 1'b0;
      resp_hit <= 1'b0;
    end else if (way_record_en) begin
      way_sel  <= way_record_in;
      resp_hit <= hit;
    end
  end

  // ----------------------------
  // Valid and LRU bit tables
  // ----------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_bits_0 <= '0;
      valid_bits_1 <= '0;
      lru_bits     <= '0;
    end else begin
      if (valid_bits_wen && !way_sel) valid_bits_0[cachereq_idx] <= 1'b1;
      if (valid_bits_wen && way_sel)  valid_bits_1[cachereq_idx] <= 1'b1;
      // Point away from the way just used
      if (lru_bits_wen) lru_bits[cachereq_idx] <= !way_sel;
    end
  end

  // ----------------------------
  // Assertions
  // ----------------------------

  a_req_resp_exclusive: assert property (
    @(posedge clk) disable iff (reset) !(cachereq_rdy && cacheresp_val)
  ) else $error("cachereq_rdy and cacheresp_val high together");

  a_memreq_held: assert property (
    @(posedge clk) disable iff (reset) (memreq_val && !memreq_rdy) |=> memreq_val
  ) else $error("memreq_val dropped before memreq_rdy");

endmodule

//--- hdl/pfb_pkg.sv
/*
  Shared types and address-field sizes for the prefetch buffer.
  Imported by the control unit, the datapath, the top level and the testbench.
*/

package pfb_pkg;

  // ----------------------------
  // Address and data sizes
  // ----------------------------

  localparam int addr_nbits   = 32;
  localparam int data_nbits   = 32;
  localparam int line_nbits   = 128;

  // Byte offset within a line whose bits 3..2 pick the word
  localparam int offset_nbits = 4;

  // Set index sits right above the offset (address bits 6..4)
  localparam int idx_nbits    = 3;
  localparam int nsets        = 8;

  // Remaining upper bits (31..7)
  localparam int tag_nbits    = addr_nbits - idx_nbits - offset_nbits;

  // ----------------------------
  // Request types
  // ----------------------------

  typedef enum logic [0:0] {
    pfb_read     = 1'b0,
    pfb_prefetch = 1'b1
  } pfb_req_e;

  // ----------------------------
  // Control FSM states
  // ----------------------------

  typedef enum logic [2:0] {
    state_idle           = 3'd0,
    state_tag_check      = 3'd1,
    state_read_access    = 3'd2,
    state_refill_request = 3'd3,
    state_refill_wait    = 3'd4,
    state_refill_update  = 3'd5,
    state_wait           = 3'd6
  } pfb_state_e;

endpackage
